/* build.f */
source/rename_pkg.sv
source/checkpoint_if.sv
source/free_list.sv
source/map_table.sv
source/checkpoint_store.sv
source/rename_unit.sv
bench/rename_tb.sv

/* run.sh */
#!/bin/sh
# build the rename unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module rename_tb -o rename_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi
output=$(./obj_dir/rename_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* bench/rename_tb.sv */
`timescale 1ns/10ps

module rename_tb;

	// directed tests take about 80 cycles and the random stream 300 more
	localparam int MAX_CYCLES = 2000;
	localparam int RANDOM_CYCLES = 300;

	logic clock;
	logic reset;
	logic dispatch_valid;
	rename_pkg::arch_reg_t arch_src1;
	rename_pkg::arch_reg_t arch_src2;
	rename_pkg::arch_reg_t arch_dest;
	logic retire_valid;
	rename_pkg::phys_reg_t retire_reg;
	logic branch_dispatch;
	logic branch_mispredict;
	logic branch_correct;
	rename_pkg::phys_reg_t phys_src1;
	rename_pkg::phys_reg_t phys_src2;
	rename_pkg::phys_reg_t phys_dest;
	rename_pkg::phys_reg_t phys_old;
	logic stall;
	rename_pkg::fl_count_t num_free;

	// reference model of map and free list
	rename_pkg::phys_reg_t ref_map [rename_pkg::NUM_ARCH_REG];
	rename_pkg::phys_reg_t ref_fl [$];
	// old tags of dispatched instructions still in flight with the oldest first
	rename_pkg::phys_reg_t rob [$];
	// model of the branch checkpoint
	logic ref_valid;
	rename_pkg::phys_reg_t saved_map [rename_pkg::NUM_ARCH_REG];
	rename_pkg::phys_reg_t saved_fl [$];
	// in-flight entries older than the branch
	int rob_mark;

	logic [15:0] lfsr_state;
	int cycle_count = 0;

	rename_unit dut_i (
		.clock             (clock),
		.reset             (reset),
		.dispatch_valid    (dispatch_valid),
		.arch_src1         (arch_src1),
		.arch_src2         (arch_src2),
		.arch_dest         (arch_dest),
		.retire_valid      (retire_valid),
		.retire_reg        (retire_reg),
		.branch_dispatch   (branch_dispatch),
		.branch_mispredict (branch_mispredict),
		.branch_correct    (branch_correct),
		.phys_src1         (phys_src1),
		.phys_src2         (phys_src2),
		.phys_dest         (phys_dest),
		.phys_old          (phys_old),
		.stall             (stall),
		.num_free          (num_free)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Done: errors found");
			$fatal(1, "timeout");
		end
	end

	task automatic check(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Done: errors found");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// galois lfsr with taps 16 14 13 11 and one step per bit
	function automatic int random_bits(input int count);
		int value;
		logic out;
		value = 0;
		for (int i = 0; i < count; i++) begin
			out = lfsr_state[0];
			lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hB400 : 16'h0000);
			value = (value << 1) | int'(out);
		end
		return value;
	endfunction

	task automatic reset_model();
		for (int i = 0; i < rename_pkg::NUM_ARCH_REG; i++) begin
			ref_map[i] = rename_pkg::phys_reg_t'(i);
		end
		ref_fl.delete();
		// physical 8..15 are free after reset
		for (int i = 0; i < rename_pkg::FL_SIZE; i++) begin
			ref_fl.push_back(rename_pkg::phys_reg_t'(rename_pkg::NUM_ARCH_REG + i));
		end
		rob.delete();
		saved_fl.delete();
		ref_valid = 1'b0;
		rob_mark = 0;
	endtask

	task automatic apply_reset();
		@(posedge clock);
		reset <= 1'b1;
		dispatch_valid <= 1'b0;
		retire_valid <= 1'b0;
		branch_dispatch <= 1'b0;
		branch_mispredict <= 1'b0;
		branch_correct <= 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		reset_model();
	endtask

	// state change that the next rising edge makes
	task automatic update_model(input logic disp, input rename_pkg::arch_reg_t dest,
			input logic ret, input rename_pkg::phys_reg_t rr,
			input logic bd, input logic bm, input logic bc);
		logic take;
		logic restore;
		logic grant;
		int size_before;
		take = bd && !ref_valid;
		restore = bm && ref_valid;
		grant = disp && ref_fl.size() > 0 && !restore;
		size_before = ref_fl.size();
		// saved copy starts from the state before this edge
		if (take) begin
			saved_map = ref_map;
			saved_fl = ref_fl;
			rob_mark = rob.size();
		end
		// retirements also land in the saved list
		if ((take || ref_valid) && ret) begin
			if (saved_fl.size() < rename_pkg::FL_SIZE) saved_fl.push_back(rr);
			if (rob_mark > 0) rob_mark = rob_mark - 1;
		end
		if (ret) void'(rob.pop_front());
		if (restore) begin
			ref_map = saved_map;
			ref_fl = saved_fl;
			// wrong path instructions leave the machine
			while (rob.size() > rob_mark) void'(rob.pop_back());
		end else begin
			if (grant) begin
				rob.push_back(ref_map[dest]);
				ref_map[dest] = ref_fl.pop_front();
			end
			if (ret && (grant || size_before < rename_pkg::FL_SIZE)) ref_fl.push_back(rr);
		end
		if (take) ref_valid = 1'b1;
		else if (bm || bc) ref_valid = 1'b0;
	endtask

	// drive one cycle on the rising edge and check at the falling edge
	task automatic do_cycle(input string name, input logic disp,
			input rename_pkg::arch_reg_t s1, input rename_pkg::arch_reg_t s2,
			input rename_pkg::arch_reg_t dest, input logic ret,
			input logic bd, input logic bm, input logic bc);
		rename_pkg::phys_reg_t rr;
		rr = '0;
		if (ret && rob.size() > 0) rr = rob[0];
		@(posedge clock);
		dispatch_valid <= disp;
		arch_src1 <= s1;
		arch_src2 <= s2;
		arch_dest <= dest;
		retire_valid <= ret;
		retire_reg <= rr;
		branch_dispatch <= bd;
		branch_mispredict <= bm;
		branch_correct <= bc;
		@(negedge clock);
		check({name, " phys_src1"}, int'(ref_map[s1]), int'(phys_src1));
		check({name, " phys_src2"}, int'(ref_map[s2]), int'(phys_src2));
		check({name, " phys_old"}, int'(ref_map[dest]), int'(phys_old));
		check({name, " num_free"}, ref_fl.size(), int'(num_free));
		check({name, " stall"}, int'(ref_fl.size() == 0), int'(stall));
		if (ref_fl.size() > 0) check({name, " phys_dest"}, int'(ref_fl[0]), int'(phys_dest));
		update_model(disp, dest, ret, rr, bd, bm, bc);
	endtask

	task automatic reset_state();
		apply_reset();
		for (int i = 0; i < rename_pkg::NUM_ARCH_REG; i++) begin
			do_cycle("reset", 1'b0, rename_pkg::arch_reg_t'(i), rename_pkg::arch_reg_t'(7 - i),
				rename_pkg::arch_reg_t'(i), 1'b0, 1'b0, 1'b0, 1'b0);
			check("reset identity", i, int'(phys_src1));
			check("reset identity", 7 - i, int'(phys_src2));
			check("reset num_free", rename_pkg::FL_SIZE, int'(num_free));
		end
	endtask

	task automatic fill_until_stall();
		rename_pkg::arch_reg_t dest;
		apply_reset();
		// destinations 0 3 6 1 4 7 2 5 all still on their identity mapping
		for (int i = 0; i < rename_pkg::FL_SIZE; i++) begin
			dest = rename_pkg::arch_reg_t'(i * 3);
			do_cycle("fill", 1'b1, dest, dest, dest, 1'b0, 1'b0, 1'b0, 1'b0);
			check("fill phys_dest", rename_pkg::NUM_ARCH_REG + i, int'(phys_dest));
			check("fill phys_old", int'(dest), int'(phys_old));
		end
		do_cycle("fill stalled", 1'b1, '0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		check("fill stall", 1, int'(stall));
		// the stalled dispatch must not have renamed arch 0
		do_cycle("fill after stall", 1'b0, '0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		check("fill after stall", 8, int'(phys_src1));
		check("fill after stall num_free", 0, int'(num_free));
	endtask

	task automatic retire_order();
		int exp_order [$];
		apply_reset();
		for (int i = 1; i <= 4; i++) begin
			do_cycle("retire setup", 1'b1, '0, '0, rename_pkg::arch_reg_t'(i), 1'b0, 1'b0,
				1'b0, 1'b0);
		end
		// old tags 1 2 3 come back in retire order
		for (int i = 0; i < 3; i++) begin
			do_cycle("retire", 1'b0, '0, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
			check("retire num_free", 4 + i, int'(num_free));
		end
		exp_order = '{12, 13, 14, 15, 1, 2, 3};
		for (int i = 0; i < 7; i++) begin
			do_cycle("retire drain", 1'b1, '0, '0, 3'd5, 1'b0, 1'b0, 1'b0, 1'b0);
			check("retire order", exp_order[i], int'(phys_dest));
			check("retire drain num_free", 7 - i, int'(num_free));
		end
	endtask

	task automatic overlap_dispatch_retire();
		int exp_order [$];
		apply_reset();
		for (int i = 5; i <= 7; i++) begin
			do_cycle("same setup", 1'b1, '0, '0, rename_pkg::arch_reg_t'(i), 1'b0, 1'b0,
				1'b0, 1'b0);
		end
		// pop 11 and push old tag 5 on one edge
		do_cycle("same cycle", 1'b1, '0, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
		check("same cycle num_free", 5, int'(num_free));
		exp_order = '{12, 13, 14, 15, 5};
		for (int i = 0; i < 5; i++) begin
			do_cycle("same drain", 1'b1, '0, '0, 3'd1, 1'b0, 1'b0, 1'b0, 1'b0);
			check("same drain num_free", 5 - i, int'(num_free));
			check("same drain order", exp_order[i], int'(phys_dest));
		end
	endtask

	task automatic checkpoint_restore();
		rename_pkg::phys_reg_t exp_map [rename_pkg::NUM_ARCH_REG];
		rename_pkg::arch_reg_t a;
		int exp_order [$];
		apply_reset();
		do_cycle("ckpt setup", 1'b1, '0, '0, 3'd1, 1'b0, 1'b0, 1'b0, 1'b0);
		do_cycle("ckpt setup", 1'b1, '0, '0, 3'd2, 1'b0, 1'b0, 1'b0, 1'b0);
		// map at the branch has arch 1 on 8 and arch 2 on 9
		for (int i = 0; i < rename_pkg::NUM_ARCH_REG; i++) begin
			exp_map[i] = rename_pkg::phys_reg_t'(i);
		end
		exp_map[1] = 4'd8;
		exp_map[2] = 4'd9;
		do_cycle("ckpt take", 1'b0, '0, '0, '0, 1'b0, 1'b1, 1'b0, 1'b0);
		// wrong path dispatches with the retire of old tag 1 in between
		do_cycle("ckpt wrong path", 1'b1, '0, '0, 3'd3, 1'b0, 1'b0, 1'b0, 1'b0);
		do_cycle("ckpt wrong path", 1'b1, '0, '0, 3'd1, 1'b1, 1'b0, 1'b0, 1'b0);
		do_cycle("ckpt wrong path", 1'b1, '0, '0, 3'd5, 1'b0, 1'b0, 1'b0, 1'b0);
		// old tag 2 retires on the mispredict edge and the dispatch is dropped
		do_cycle("ckpt mispredict", 1'b1, '0, '0, 3'd6, 1'b1, 1'b0, 1'b1, 1'b0);
		for (int i = 0; i < rename_pkg::NUM_ARCH_REG; i++) begin
			a = rename_pkg::arch_reg_t'(i);
			do_cycle("ckpt restored", 1'b0, a, a, a, 1'b0, 1'b0, 1'b0, 1'b0);
			check("ckpt restored map", int'(exp_map[a]), int'(phys_src1));
			check("ckpt restored num_free", 8, int'(num_free));
		end
		exp_order = '{10, 11, 12, 13, 14, 15, 1, 2};
		for (int i = 0; i < 8; i++) begin
			do_cycle("ckpt drain", 1'b1, '0, '0, 3'd4, 1'b0, 1'b0, 1'b0, 1'b0);
			check("ckpt drain order", exp_order[i], int'(phys_dest));
		end
	endtask

	task automatic random_stream();
		logic disp;
		logic ret;
		logic bd;
		logic bc;
		int kind;
		apply_reset();
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			kind = random_bits(3);
			bd = !ref_valid && kind == 0;
			bc = ref_valid && kind == 1;
			// a branch never shares its cycle with a dispatch
			disp = !bd && random_bits(1) == 1;
			// while a branch is open only instructions older than it retire
			ret = random_bits(1) == 1 && rob.size() > 0 && (!ref_valid || rob_mark > 0);
			do_cycle("random", disp, rename_pkg::arch_reg_t'(random_bits(3)),
				rename_pkg::arch_reg_t'(random_bits(3)), rename_pkg::arch_reg_t'(random_bits(3)),
				ret, bd, 1'b0, bc);
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		dispatch_valid = 1'b0;
		arch_src1 = '0;
		arch_src2 = '0;
		arch_dest = '0;
		retire_valid = 1'b0;
		retire_reg = '0;
		branch_dispatch = 1'b0;
		branch_mispredict = 1'b0;
		branch_correct = 1'b0;
		lfsr_state = 16'd24;
		reset_state();
		fill_until_stall();
		retire_order();
		overlap_dispatch_retire();
		checkpoint_restore();
		random_stream();
		$display("Done: no errors");
		$finish;
	end

endmodule

/* source/rename_unit.sv */
`timescale 1ns/10ps

module rename_unit (
	input  logic clock,
	input  logic reset,
	input  logic dispatch_valid,
	input  rename_pkg::arch_reg_t arch_src1,
	input  rename_pkg::arch_reg_t arch_src2,
	input  rename_pkg::arch_reg_t arch_dest,
	input  logic retire_valid,
	input  rename_pkg::phys_reg_t retire_reg,
	input  logic branch_dispatch,
	input  logic branch_mispredict,
	input  logic branch_correct,
	output rename_pkg::phys_reg_t phys_src1,
	output rename_pkg::phys_reg_t phys_src2,
	output rename_pkg::phys_reg_t phys_dest,
	output rename_pkg::phys_reg_t phys_old,
	output logic stall,
	output rename_pkg::fl_count_t num_free
);

	// free list to map table
	logic grant;
	rename_pkg::phys_reg_t new_reg;

	// snapshot and restore bus around the checkpoint
	checkpoint_if ckpt_bus ();

	// head of the free list is the new destination
	assign phys_dest = new_reg;

	free_list free_list_i (
		.clock          (clock),
		.reset          (reset),
		.dispatch_valid (dispatch_valid),
		.retire_valid   (retire_valid),
		.retire_reg     (retire_reg),
		.grant          (grant),
		.new_reg        (new_reg),
		.stall          (stall),
		.num_free       (num_free),
		.ckpt           (ckpt_bus.free)
	);

	map_table map_table_i (
		.clock     (clock),
		.reset     (reset),
		.grant     (grant),
		.arch_src1 (arch_src1),
		.arch_src2 (arch_src2),
		.arch_dest (arch_dest),
		.new_reg   (new_reg),
		.phys_src1 (phys_src1),
		.phys_src2 (phys_src2),
		.phys_old  (phys_old),
		.ckpt      (ckpt_bus.map)
	);

	checkpoint_store checkpoint_store_i (
		.clock             (clock),
		.reset             (reset),
		.branch_dispatch   (branch_dispatch),
		.branch_mispredict (branch_mispredict),
		.branch_correct    (branch_correct),
		.retire_valid      (retire_valid),
		.retire_reg        (retire_reg),
		.ckpt              (ckpt_bus.store)
	);

endmodule

/* source/checkpoint_store.sv */
`timescale 1ns/10ps

module checkpoint_store (
	input  logic clock,
	input  logic reset,
	input  logic branch_dispatch,
	input  logic branch_mispredict,
	input  logic branch_correct,
	input  logic retire_valid,
	input  rename_pkg::phys_reg_t retire_reg,
	checkpoint_if.store ckpt
);

	// one outstanding branch at most
	logic valid;

	// saved copy of map and free list
	rename_pkg::map_array_t saved_map;
	rename_pkg::fl_array_t saved_fl;
	rename_pkg::fl_count_t saved_tail;

	// list the retire is appended to, either live or saved
	rename_pkg::fl_array_t base_fl;
	rename_pkg::fl_count_t base_tail;
	rename_pkg::fl_array_t append_fl;
	rename_pkg::fl_count_t append_tail;

	// strobes are qualified with the valid flag so a stray branch event is harmless
	assign ckpt.take = branch_dispatch && !valid;
	assign ckpt.restore = branch_mispredict && valid;

	// on a take the saved copy starts from the live list
	assign base_fl = ckpt.take ? ckpt.fl_snapshot : saved_fl;
	assign base_tail = ckpt.take ? ckpt.tail_snapshot : saved_tail;

	// retires are committed work, they belong in the saved copy too
	always_comb begin
		append_fl = base_fl;
		append_tail = base_tail;
		if (retire_valid && base_tail != rename_pkg::fl_count_t'(rename_pkg::FL_SIZE)) begin
			append_fl[rename_pkg::fl_index_t'(base_tail)] = retire_reg;
			append_tail = base_tail + 1'b1;
		end
	end

	// restore values include a retire from the mispredict cycle itself
	assign ckpt.fl_restore = append_fl;
	assign ckpt.tail_restore = append_tail;
	assign ckpt.map_restore = saved_map;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (ckpt.take) begin
			valid <= 1'b1;
		end else if (branch_mispredict || branch_correct) begin
			// resolved either way, the copy is no longer needed
			valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ckpt.take) begin
			saved_map <= ckpt.map_snapshot;
		end
		if (ckpt.take || valid) begin
			saved_fl <= append_fl;
			saved_tail <= append_tail;
		end
	end

	// only one checkpoint, a second branch must wait for the first to resolve
	a_take_single: assert property (
		@(posedge clock) disable iff (reset)
		branch_dispatch |-> !valid
	);

	// resolution without an outstanding branch points at a front end bug
	a_resolve_valid: assert property (
		@(posedge clock) disable iff (reset)
		(branch_mispredict || branch_correct) |-> valid
	);

endmodule

/* source/map_table.sv */
`timescale 1ns/10ps

module map_table (
	input  logic clock,
	input  logic reset,
	input  logic grant,
	input  rename_pkg::arch_reg_t arch_src1,
	input  rename_pkg::arch_reg_t arch_src2,
	input  rename_pkg::arch_reg_t arch_dest,
	input  rename_pkg::phys_reg_t new_reg,
	output rename_pkg::phys_reg_t phys_src1,
	output rename_pkg::phys_reg_t phys_src2,
	output rename_pkg::phys_reg_t phys_old,
	checkpoint_if.map ckpt
);

	// current physical name of each architectural register
	rename_pkg::map_array_t map;
	rename_pkg::map_array_t next_map;

	// source lookups see the table before this instruction's own write
	// so an instruction reading its own destination gets the older producer
	assign phys_src1 = map[arch_src1];
	assign phys_src2 = map[arch_src2];

	// previous owner of the destination, freed when this instruction retires
	assign phys_old = map[arch_dest];

	// live copy for the checkpoint store
	assign ckpt.map_snapshot = map;

	always_comb begin
		next_map = map;
		if (ckpt.restore) begin
			// mispredict reloads the whole table
			// any rename in the same cycle is on the wrong path and is dropped
			next_map = ckpt.map_restore;
		end else if (grant) begin
			// only granted dispatches rename
			// a stalled dispatch leaves the table alone
			next_map[arch_dest] = new_reg;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity mapping, arch i on phys i
			for (int i = 0; i < rename_pkg::NUM_ARCH_REG; i++) begin
				map[i] <= rename_pkg::phys_reg_t'(i);
			end
		end else begin
			map <= next_map;
		end
	end

endmodule

/* source/free_list.sv */
`timescale 1ns/10ps

module free_list (
	input  logic clock,
	input  logic reset,
	input  logic dispatch_valid,
	input  logic retire_valid,
	input  rename_pkg::phys_reg_t retire_reg,
	output logic grant,
	output rename_pkg::phys_reg_t new_reg,
	output logic stall,
	output rename_pkg::fl_count_t num_free,
	checkpoint_if.free ckpt
);

	// queue storage with the head at entry 0
	rename_pkg::fl_array_t list;
	rename_pkg::fl_array_t next_list;

	// tail points at the first unused slot and equals the free count
	rename_pkg::fl_count_t tail;
	rename_pkg::fl_count_t next_tail;

	logic empty;
	logic full;

	assign empty = (tail == '0);
	assign full = (tail == rename_pkg::fl_count_t'(rename_pkg::FL_SIZE));

	// a dispatch only gets a register when one is left
	assign grant = dispatch_valid && !empty;
	assign new_reg = list[0];
	assign stall = empty;
	assign num_free = tail;

	// live copy for the checkpoint store
	assign ckpt.fl_snapshot = list;
	assign ckpt.tail_snapshot = tail;

	always_comb begin
		next_list = list;
		next_tail = tail;
		if (ckpt.restore) begin
			// mispredict wins over dispatch and retire
			// the restore values already carry a same-cycle retire
			next_list = ckpt.fl_restore;
			next_tail = ckpt.tail_restore;
		end else if (grant && retire_valid) begin
			// pop and push together so the count stays put
			for (int i = 0; i < rename_pkg::FL_SIZE - 1; i++) begin
				next_list[i] = list[i + 1];
			end
			// the retired tag lands in the slot the shift just vacated
			next_list[rename_pkg::fl_index_t'(tail - 1'b1)] = retire_reg;
		end else if (grant) begin
			// pop only so everything moves one place toward the head
			for (int i = 0; i < rename_pkg::FL_SIZE - 1; i++) begin
				next_list[i] = list[i + 1];
			end
			next_tail = tail - 1'b1;
		end else if (retire_valid && !full) begin
			// push only and also taken when the list is empty
			next_list[rename_pkg::fl_index_t'(tail)] = retire_reg;
			next_tail = tail + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// physical 0..7 hold the identity mapping
			// so the list starts with 8..15 in order
			for (int i = 0; i < rename_pkg::FL_SIZE; i++) begin
				list[i] <= rename_pkg::phys_reg_t'(rename_pkg::NUM_ARCH_REG + i);
			end
			tail <= rename_pkg::fl_count_t'(rename_pkg::FL_SIZE);
		end else begin
			list <= next_list;
			tail <= next_tail;
		end
	end

	// a full list can take a retire only if a dispatch frees a slot the same cycle
	// anything else means a register was freed twice somewhere upstream
	a_no_push_full: assert property (
		@(posedge clock) disable iff (reset)
		(retire_valid && full && !ckpt.restore) |-> grant
	);

	// a pop from an empty list or a bad restore would wrap the count past FL_SIZE
	a_no_pop_empty: assert property (
		@(posedge clock) disable iff (reset)
		tail <= rename_pkg::fl_count_t'(rename_pkg::FL_SIZE)
	);

endmodule

/* source/checkpoint_if.sv */
`timescale 1ns/10ps

interface checkpoint_if;

	// strobes from the checkpoint store
	logic take;
	logic restore;

	// live state shown to the store
	rename_pkg::fl_array_t fl_snapshot;
	rename_pkg::fl_count_t tail_snapshot;
	rename_pkg::map_array_t map_snapshot;

	// saved state handed back on a mispredict
	rename_pkg::fl_array_t fl_restore;
	rename_pkg::fl_count_t tail_restore;
	rename_pkg::map_array_t map_restore;

	// single branch checkpoint
	modport store (
		output take,
		output restore,
		output fl_restore,
		output tail_restore,
		output map_restore,
		input  fl_snapshot,
		input  tail_snapshot,
		input  map_snapshot
	);

	// free list side
	modport free (
		output fl_snapshot,
		output tail_snapshot,
		input  restore,
		input  fl_restore,
		input  tail_restore
	);

	// map table side
	modport map (
		output map_snapshot,
		input  restore,
		input  map_restore
	);

endinterface

/* source/rename_pkg.sv */
package rename_pkg;

	// architectural register count, also where the free list fill starts
	localparam int NUM_ARCH_REG = 8;

	// physical register file size
	localparam int NUM_PHYS_REG = 16;

	// registers not bound to an architectural name at reset
	localparam int FL_SIZE = NUM_PHYS_REG - NUM_ARCH_REG;

	// architectural register index
	typedef logic [$clog2(NUM_ARCH_REG)-1:0] arch_reg_t;

	// physical register tag
	typedef logic [$clog2(NUM_PHYS_REG)-1:0] phys_reg_t;

	// free entry count, 0 up to FL_SIZE inclusive, doubles as the tail pointer
	typedef logic [$clog2(FL_SIZE):0] fl_count_t;

	// position inside the free list
	typedef logic [$clog2(FL_SIZE)-1:0] fl_index_t;

	// whole free list, entry 0 is the head
	typedef phys_reg_t [FL_SIZE-1:0] fl_array_t;

	// whole map table, indexed by architectural register
	typedef phys_reg_t [NUM_ARCH_REG-1:0] map_array_t;

endpackage
